// File: all.f
+incdir+design
design/mem_pkg.sv
design/mem_decode.sv
design/l15_request_fsm.sv
design/load_extend.sv
design/mem_wrap.sv
test/mem_wrap_assert.sv
test/mem_wrap_tb.sv

// File: run.sh
#!/bin/bash
# builds the memory stage testbench with Verilator and runs it
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert \
    -f all.f \
    --top-module mem_wrap_tb \
    -o sim_mem_wrap

# the log decides, so a stopped simulation must not end the script early
./obj_dir/sim_mem_wrap > sim.log 2>&1 || true
cat sim.log

if grep -q "^PASS: all tests$" sim.log; then
    exit 0
fi
exit 1

// File: test/mem_wrap_tb.sv
`timescale 1ns/1ns
////////////////////////////////////////////////////////////
// memory stage testbench with an L1.5 responder model
// memory image is 64 bytes, address bits above 5 ignored
////////////////////////////////////////////////////////////
`include "mem_params.svh"

module mem_wrap_tb;

    typedef struct {
        string             name;
        mem_pkg::mem_op_t  op;
        mem_pkg::word_t    base;
        mem_pkg::word_t    off_i;
        mem_pkg::word_t    off_s;
        mem_pkg::word_t    sdata;
        logic              exp_req;      // a request goes out
        logic [3:0]        exp_rqtype;
        logic [2:0]        exp_size;
        mem_pkg::word_t    exp_addr;
        mem_pkg::word_t    exp_load;     // load_data after the op
        logic              exp_lmis;
        logic              exp_smis;
    } test_entry_t;

    logic clk = 1'b0;
    logic nrst;
    mem_pkg::mem_op_t   op;
    mem_pkg::word_t     base, offset_i, offset_s, store_data;
    mem_pkg::l15_resp_t l15_resp;
    mem_pkg::l15_req_t  l15_req;
    logic               req_ack, done, active, ld_misaligned, st_misaligned;
    mem_pkg::word_t     load_data;

    test_entry_t       table_q[$];
    logic [7:0]        mem_img [64];
    mem_pkg::l15_req_t cap_req;          // request as accepted
    logic              armed = 1'b0;     // responder may accept
    logic              table_built = 1'b0;
    int                err_count = 0;
    int                fail_tests = 0;
    int                done_count = 0;
    int                accept_count = 0;

    mem_wrap i_dut (
        .clk(clk), .nrst(nrst), .op(op), .base(base), .offset_i(offset_i),
        .offset_s(offset_s), .store_data(store_data), .l15_resp(l15_resp),
        .l15_req(l15_req), .req_ack(req_ack), .load_data(load_data), .done(done),
        .active(active), .ld_misaligned(ld_misaligned), .st_misaligned(st_misaligned)
    );

    always #50 clk = ~clk;

    function automatic mem_pkg::word_t byte_reverse(input mem_pkg::word_t w);
        return {w[7:0], w[15:8], w[23:16], w[31:24]};
    endfunction

    task automatic report_mismatch(input string name, input string what,
                                   input logic [63:0] exp, input logic [63:0] act);
        $display("Mismatch in %s (%s): expected %h, actual %h", name, what, exp, act);
        err_count++;
    endtask

    task automatic add_entry(input string name, input mem_pkg::mem_op_t op_v,
                             input mem_pkg::word_t b, input mem_pkg::word_t oi,
                             input mem_pkg::word_t os, input mem_pkg::word_t sd,
                             input logic rq, input logic [3:0] rt, input logic [2:0] sz,
                             input mem_pkg::word_t ea, input mem_pkg::word_t el,
                             input logic lm, input logic sm);
        test_entry_t e;
        e = '{name, op_v, b, oi, os, sd, rq, rt, sz, ea, el, lm, sm};
        table_q.push_back(e);
    endtask

    // store bytes land at the big-endian lane given by address[2:0]
    function automatic void apply_store(input mem_pkg::l15_req_t r);
        int nbytes;
        int pos;
        nbytes = 1 << (r.size - 1);
        pos = int'(r.address[2:0]);
        for (int k = 0; k < nbytes; k++) begin
            mem_img[int'(r.address[5:0]) + k] = r.data[8 * (7 - (pos + k)) +: 8];
        end
    endfunction

    initial begin : responder
        mem_pkg::l15_req_t first;
        int unsigned ack_wait;
        int unsigned resp_wait;
        int line;
        l15_resp = '0;
        forever begin
            @(posedge clk);
            #1;
            if (armed && l15_req.val) begin
                first = l15_req;
                ack_wait = $urandom % 4;
                repeat (ack_wait) begin
                    @(posedge clk);
                    #1;
                    if (l15_req != first) begin
                        $display("request changed while header_ack was held low");
                        err_count++;
                    end
                end
                l15_resp.header_ack = 1'b1;
                cap_req = l15_req;
                @(posedge clk);
                #1;
                l15_resp.header_ack = 1'b0;
                if (first.rqtype == `STORE_RQ) begin
                    apply_store(first);
                end
                resp_wait = 1 + $urandom % 4;
                repeat (resp_wait - 1) begin
                    @(posedge clk);
                    #1;
                end
                // interrupt return first, must be ignored
                l15_resp.val = 1'b1;
                l15_resp.returntype = `INT_RET;
                l15_resp.data_0 = '1;
                l15_resp.data_1 = '1;
                @(posedge clk);
                #1;
                line = int'({first.address[5:4], 4'b0000});
                for (int k = 0; k < 8; k++) begin
                    l15_resp.data_0[8 * (7 - k) +: 8] = mem_img[line + k];
                    l15_resp.data_1[8 * (7 - k) +: 8] = mem_img[line + 8 + k];
                end
                l15_resp.returntype = (first.rqtype == `STORE_RQ) ? `ST_ACK : `LOAD_RET;
                @(posedge clk);
                #1;
                l15_resp.val = 1'b0;
            end
        end
    end

    always @(negedge clk) begin
        if (nrst) begin
            if (done) done_count++;
            if (l15_req.val && l15_resp.header_ack) accept_count++;
            if (done && l15_resp.val && l15_resp.returntype == `INT_RET) begin
                $display("done raised on an interrupt return");
                err_count++;
            end
        end
    end

    task automatic run_entry(input test_entry_t e);
        int   errs_before;
        int   cycles;
        logic finished;
        logic val_seen;
        logic lmis_got;
        logic smis_got;
        logic active_got;
        logic exp_active;
        errs_before = err_count;
        finished = 1'b0;
        val_seen = 1'b0;
        cycles = 0;
        exp_active = (e.op != mem_pkg::NO_OP);    // any nonzero op
        @(posedge clk);
        #1;
        op = e.op;
        base = e.base;
        offset_i = e.off_i;
        offset_s = e.off_s;
        store_data = e.sdata;
        armed = e.exp_req;
        while (!finished && cycles < 20) begin
            @(negedge clk);
            cycles++;
            if (!e.exp_req && l15_req.val) val_seen = 1'b1;
            finished = e.exp_req ? done : (ld_misaligned | st_misaligned);
        end
        lmis_got = ld_misaligned;
        smis_got = st_misaligned;
        active_got = active;
        armed = 1'b0;
        @(posedge clk);
        #1;
        op = mem_pkg::NO_OP;
        repeat (3) begin    // old op drains from both decoder stages
            @(negedge clk);
            if (!e.exp_req && l15_req.val) val_seen = 1'b1;
        end
        if (!finished) begin
            $display("%s did not finish within 20 cycles", e.name);
            err_count++;
        end else if (e.exp_req) begin
            if (cap_req.rqtype != e.exp_rqtype)
                report_mismatch(e.name, "rqtype", 64'(e.exp_rqtype), 64'(cap_req.rqtype));
            if (cap_req.size != e.exp_size)
                report_mismatch(e.name, "size", 64'(e.exp_size), 64'(cap_req.size));
            if (cap_req.address != e.exp_addr)
                report_mismatch(e.name, "address", 64'(e.exp_addr), 64'(cap_req.address));
            if (e.exp_rqtype == `STORE_RQ &&
                cap_req.data != {byte_reverse(e.sdata), byte_reverse(e.sdata)})
                report_mismatch(e.name, "data",
                                {byte_reverse(e.sdata), byte_reverse(e.sdata)}, cap_req.data);
        end
        if (lmis_got != e.exp_lmis)
            report_mismatch(e.name, "ld_misaligned", 64'(e.exp_lmis), 64'(lmis_got));
        if (smis_got != e.exp_smis)
            report_mismatch(e.name, "st_misaligned", 64'(e.exp_smis), 64'(smis_got));
        if (active_got != exp_active)
            report_mismatch(e.name, "active", 64'(exp_active), 64'(active_got));
        if (active)
            report_mismatch(e.name, "active after no-op", 64'h0, 64'(active));
        if (val_seen) begin
            $display("%s issued a request although it is misaligned", e.name);
            err_count++;
        end
        if (load_data != e.exp_load)
            report_mismatch(e.name, "load_data", 64'(e.exp_load), 64'(load_data));
        if (err_count == errs_before) begin
            $display("test %s ok", e.name);
        end else begin
            $display("test %s failed", e.name);
            fail_tests++;
        end
    endtask

    initial begin : watchdog
        wait (table_built);
        #((table_q.size() * 20 + 8) * 100);
        $display("watchdog expired before the tests finished");
        $display("FAIL: see errors above");
        $finish;
    end

    initial begin : main
        int exp_requests;
        void'($urandom(50));
        nrst = 1'b0;
        op = mem_pkg::NO_OP;
        base = '0;
        offset_i = '0;
        offset_s = '0;
        store_data = '0;
        for (int i = 0; i < 64; i++) mem_img[i] = 8'(i * 37 + 11);
        add_entry("sw_word_a", mem_pkg::SW, 32'h1000, 32'h40, 32'h10, 32'h87654321,
                  1, `STORE_RQ, `MSG_SIZE_4B, 32'h1010, 32'h0, 0, 0);
        add_entry("sw_word_b", mem_pkg::SW, 32'h1000, 32'h04, 32'h1C, 32'h11223344,
                  1, `STORE_RQ, `MSG_SIZE_4B, 32'h101C, 32'h0, 0, 0);
        add_entry("sh_lower", mem_pkg::SH, 32'h1020, 32'h08, 32'h00, 32'h0000F00D,
                  1, `STORE_RQ, `MSG_SIZE_2B, 32'h1020, 32'h0, 0, 0);
        add_entry("sh_upper", mem_pkg::SH, 32'h1020, 32'h08, 32'h02, 32'h80010000,
                  1, `STORE_RQ, `MSG_SIZE_2B, 32'h1022, 32'h0, 0, 0);
        add_entry("sb_lane0", mem_pkg::SB, 32'h1020, 32'h00, 32'h04, 32'h00000080,
                  1, `STORE_RQ, `MSG_SIZE_1B, 32'h1024, 32'h0, 0, 0);
        add_entry("sb_lane3", mem_pkg::SB, 32'h1020, 32'h00, 32'h07, 32'h7F000000,
                  1, `STORE_RQ, `MSG_SIZE_1B, 32'h1027, 32'h0, 0, 0);
        add_entry("sb_lane1", mem_pkg::SB, 32'h1020, 32'h00, 32'h05, 32'h00005A00,
                  1, `STORE_RQ, `MSG_SIZE_1B, 32'h1025, 32'h0, 0, 0);
        add_entry("sb_lane2", mem_pkg::SB, 32'h1020, 32'h00, 32'h06, 32'h00C30000,
                  1, `STORE_RQ, `MSG_SIZE_1B, 32'h1026, 32'h0, 0, 0);
        add_entry("lw_word_a", mem_pkg::LW, 32'h1000, 32'h10, 32'h100, 32'h0,
                  1, `LOAD_RQ, `MSG_SIZE_4B, 32'h1010, 32'h87654321, 0, 0);
        add_entry("lw_word_b", mem_pkg::LW, 32'h1010, 32'h0C, 32'h100, 32'h0,
                  1, `LOAD_RQ, `MSG_SIZE_4B, 32'h101C, 32'h11223344, 0, 0);
        add_entry("lh_upper_neg", mem_pkg::LH, 32'h1020, 32'h02, 32'h100, 32'h0,
                  1, `LOAD_RQ, `MSG_SIZE_4B, 32'h1022, 32'hFFFF8001, 0, 0);
        add_entry("lhu_upper", mem_pkg::LHU, 32'h1020, 32'h02, 32'h100, 32'h0,
                  1, `LOAD_RQ, `MSG_SIZE_4B, 32'h1022, 32'h00008001, 0, 0);
        add_entry("lh_lower_pos", mem_pkg::LH, 32'h1000, 32'h10, 32'h100, 32'h0,
                  1, `LOAD_RQ, `MSG_SIZE_4B, 32'h1010, 32'h00004321, 0, 0);
        add_entry("lb_neg", mem_pkg::LB, 32'h1020, 32'h04, 32'h100, 32'h0,
                  1, `LOAD_RQ, `MSG_SIZE_4B, 32'h1024, 32'hFFFFFF80, 0, 0);
        add_entry("lbu_high", mem_pkg::LBU, 32'h1020, 32'h04, 32'h100, 32'h0,
                  1, `LOAD_RQ, `MSG_SIZE_4B, 32'h1024, 32'h00000080, 0, 0);
        add_entry("lb_pos", mem_pkg::LB, 32'h1020, 32'h07, 32'h100, 32'h0,
                  1, `LOAD_RQ, `MSG_SIZE_4B, 32'h1027, 32'h0000007F, 0, 0);
        add_entry("lb_lane1", mem_pkg::LB, 32'h1020, 32'h05, 32'h100, 32'h0,
                  1, `LOAD_RQ, `MSG_SIZE_4B, 32'h1025, 32'h0000005A, 0, 0);
        add_entry("lw_bytes", mem_pkg::LW, 32'h1020, 32'h04, 32'h100, 32'h0,
                  1, `LOAD_RQ, `MSG_SIZE_4B, 32'h1024, 32'h7FC35A80, 0, 0);
        add_entry("lh_odd", mem_pkg::LH, 32'h1020, 32'h01, 32'h100, 32'h0,
                  0, `LOAD_RQ, `MSG_SIZE_4B, 32'h1021, 32'h7FC35A80, 1, 0);
        add_entry("lw_odd", mem_pkg::LW, 32'h1010, 32'h03, 32'h100, 32'h0,
                  0, `LOAD_RQ, `MSG_SIZE_4B, 32'h1013, 32'h7FC35A80, 1, 0);
        add_entry("sw_bit1", mem_pkg::SW, 32'h1010, 32'h00, 32'h02, 32'hCAFEBABE,
                  0, `STORE_RQ, `MSG_SIZE_4B, 32'h1012, 32'h7FC35A80, 0, 1);
        add_entry("lw_after", mem_pkg::LW, 32'h1000, 32'h10, 32'h100, 32'h0,
                  1, `LOAD_RQ, `MSG_SIZE_4B, 32'h1010, 32'h87654321, 0, 0);
        table_built = 1'b1;

        repeat (8) @(posedge clk);
        #1;
        nrst = 1'b1;
        @(negedge clk);
        if (l15_req.val || done || req_ack || active || ld_misaligned || st_misaligned) begin
            $display("control outputs not low right after reset");
            err_count++;
        end
        if (load_data != '0)
            report_mismatch("reset", "load_data", 64'h0, 64'(load_data));

        exp_requests = 0;
        foreach (table_q[i]) begin
            run_entry(table_q[i]);
            if (table_q[i].exp_req) exp_requests++;
        end
        if (accept_count != exp_requests)
            report_mismatch("counts", "accepted", 64'(exp_requests), 64'(accept_count));
        if (done_count != exp_requests)
            report_mismatch("counts", "done pulses", 64'(exp_requests), 64'(done_count));

        $display("tests %0d, failed %0d, errors %0d", table_q.size(), fail_tests, err_count);
        if (err_count == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// File: test/mem_wrap_assert.sv
`timescale 1ns/1ns
////////////////////////////////////////////////////////////
// L1.5 port protocol checks, bound into every mem_wrap
// the response state is tracked here from accept and done
////////////////////////////////////////////////////////////
module mem_wrap_assert (
    input logic               clk,
    input logic               nrst,
    input mem_pkg::l15_req_t  l15_req,
    input mem_pkg::l15_resp_t l15_resp,
    input logic               req_ack,
    input logic               done
);
    logic in_resp;    // request accepted, no done yet

    always_ff @(posedge clk, negedge nrst) begin
        if (!nrst) begin
            in_resp <= 1'b0;
        end else if (l15_req.val && l15_resp.header_ack) begin
            in_resp <= 1'b1;
        end else if (done) begin
            in_resp <= 1'b0;
        end
    end

    a_val_low_in_resp: assert property (@(posedge clk) disable iff (!nrst)
        in_resp |-> !l15_req.val)
        else $error("l15 request valid while awaiting the response");

    // fields frozen until accepted or withdrawn
    a_req_stable: assert property (@(posedge clk) disable iff (!nrst)
        (l15_req.val && !l15_resp.header_ack) |=>
        (!l15_req.val || $stable({l15_req.rqtype, l15_req.size,
                                  l15_req.address, l15_req.data})))
        else $error("l15 request fields changed before header_ack");

    a_done_single: assert property (@(posedge clk) disable iff (!nrst)
        done |=> !done)
        else $error("done high in two consecutive cycles");

    a_ack_on_return: assert property (@(posedge clk) disable iff (!nrst)
        (in_resp && l15_resp.val) |-> req_ack)
        else $error("return in response state not acknowledged");

endmodule

bind mem_wrap mem_wrap_assert i_assert (.*);

// File: design/mem_wrap.sv
`timescale 1ns/1ns
////////////////////////////////////////////////////////////
// memory stage top; core must hold its inputs until done
////////////////////////////////////////////////////////////
module mem_wrap (
    input  logic               clk,
    input  logic               nrst,
    input  mem_pkg::mem_op_t   op,
    input  mem_pkg::word_t     base,
    input  mem_pkg::word_t     offset_i,
    input  mem_pkg::word_t     offset_s,
    input  mem_pkg::word_t     store_data,
    input  mem_pkg::l15_resp_t l15_resp,
    output mem_pkg::l15_req_t  l15_req,
    output logic               req_ack,
    output mem_pkg::word_t     load_data,
    output logic               done,
    output logic               active,
    output logic               ld_misaligned,
    output logic               st_misaligned
);
    mem_pkg::mem_req_t req;        // stage-6 request
    logic              load_fire;

    mem_decode u_decode (
        .clk(clk), .nrst(nrst),
        .op(op), .base(base), .offset_i(offset_i), .offset_s(offset_s),
        .store_data(store_data),
        .req(req), .ld_misaligned(ld_misaligned), .st_misaligned(st_misaligned)
    );

    l15_request_fsm u_fsm (
        .clk(clk), .nrst(nrst),
        .req(req), .l15_resp(l15_resp),
        .l15_req(l15_req), .req_ack(req_ack), .load_fire(load_fire), .done(done)
    );

    load_extend u_extend (
        .clk(clk), .nrst(nrst),
        .req(req), .l15_resp(l15_resp), .load_fire(load_fire),
        .load_data(load_data)
    );

    assign active = req.active;

endmodule

// File: design/load_extend.sv
`timescale 1ns/1ns
////////////////////////////////////////////////////////////
// picks the addressed word of the returned line, swaps it
// to little-endian and extends; result held until next load
////////////////////////////////////////////////////////////
module load_extend (
    input  logic               clk,
    input  logic               nrst,
    input  mem_pkg::mem_req_t  req,
    input  mem_pkg::l15_resp_t l15_resp,
    input  logic               load_fire,
    output mem_pkg::word_t     load_data
);
    mem_pkg::word_t line_word;
    mem_pkg::word_t swapped;
    mem_pkg::word_t shifted;
    mem_pkg::word_t extended;

    always_comb begin
        case (req.addr[3:2])
            2'b00:   line_word = l15_resp.data_0[63:32];
            2'b01:   line_word = l15_resp.data_0[31:0];
            2'b10:   line_word = l15_resp.data_1[63:32];
            default: line_word = l15_resp.data_1[31:0];
        endcase
    end

    assign swapped = {line_word[7:0], line_word[15:8],
                      line_word[23:16], line_word[31:24]};

    // addressed byte or half moved down to bit 0
    assign shifted = swapped >> {req.addr[1:0], 3'b000};

    always_comb begin
        case (req.op)
            mem_pkg::LB:  extended = {{24{shifted[7]}}, shifted[7:0]};
            mem_pkg::LBU: extended = {24'b0, shifted[7:0]};
            mem_pkg::LH:  extended = {{16{shifted[15]}}, shifted[15:0]};
            mem_pkg::LHU: extended = {16'b0, shifted[15:0]};
            mem_pkg::LW:  extended = swapped;
            default:      extended = '0;
        endcase
    end

    always_ff @(posedge clk, negedge nrst) begin
        if (!nrst) begin
            load_data <= '0;
        end else if (load_fire) begin
            load_data <= extended;
        end
    end

endmodule

// File: design/l15_request_fsm.sv
`timescale 1ns/1ns
////////////////////////////////////////////////////////////
// one blocking request at a time on the L1.5 port
// val holds with fixed fields until header_ack; the return
// type must match the request type to end the operation
////////////////////////////////////////////////////////////
`include "mem_params.svh"

module l15_request_fsm (
    input  logic               clk,
    input  logic               nrst,
    input  mem_pkg::mem_req_t  req,
    input  mem_pkg::l15_resp_t l15_resp,
    output mem_pkg::l15_req_t  l15_req,
    output logic               req_ack,
    output logic               load_fire,
    output logic               done
);
    typedef enum logic {
        REQ_IDLE,
        RESP_WAIT
    } state_t;

    state_t         state;
    logic [3:0]     rqtype_r;       // type of the accepted request
    logic           want_req;
    logic           is_store;
    logic           accept;
    logic           resp_fire;
    logic           type_match;
    mem_pkg::word_t wdata_swap;

    assign is_store = |req.byte_en;
    assign want_req = req.rd | is_store;

    // core is little-endian, L1.5 is big-endian
    assign wdata_swap = {req.wdata[7:0], req.wdata[15:8],
                         req.wdata[23:16], req.wdata[31:24]};

    always_comb begin
        l15_req.rqtype  = is_store ? `STORE_RQ : `LOAD_RQ;
        l15_req.address = req.addr;
        l15_req.data    = {wdata_swap, wdata_swap};   // same word in both halves
        l15_req.val     = (state == REQ_IDLE) & want_req;
        case (req.byte_en)
            4'b1111:                            l15_req.size = `MSG_SIZE_4B;
            4'b1100, 4'b0011:                   l15_req.size = `MSG_SIZE_2B;
            4'b0001, 4'b0010, 4'b0100, 4'b1000: l15_req.size = `MSG_SIZE_1B;
            default:                            l15_req.size = `MSG_SIZE_4B; // load
        endcase
    end

    assign accept    = l15_req.val & l15_resp.header_ack;
    assign resp_fire = (state == RESP_WAIT) & l15_resp.val;

    always_comb begin
        case (l15_resp.returntype)
            `LOAD_RET: type_match = (rqtype_r == `LOAD_RQ);
            `ST_ACK:   type_match = (rqtype_r == `STORE_RQ);
            `INT_RET:  type_match = 1'b0;   // acked, otherwise dropped
            default:   type_match = 1'b0;
        endcase
    end

    always_ff @(posedge clk, negedge nrst) begin
        if (!nrst) begin
            state    <= REQ_IDLE;
            rqtype_r <= `LOAD_RQ;
        end else begin
            case (state)
                REQ_IDLE: begin
                    if (accept) begin
                        state    <= RESP_WAIT;
                        rqtype_r <= l15_req.rqtype;
                    end
                end
                RESP_WAIT: begin
                    if (resp_fire & type_match) begin
                        state <= REQ_IDLE;
                    end
                end
                default: state <= REQ_IDLE;
            endcase
        end
    end

    // every return in the response state is acknowledged
    assign req_ack   = resp_fire;
    assign done      = resp_fire & type_match;
    assign load_fire = done & (rqtype_r == `LOAD_RQ);   // data valid this cycle

endmodule

// File: design/mem_decode.sv
`timescale 1ns/1ns
////////////////////////////////////////////////////////////
// two register stages: inputs, then the decoded request
// misaligned ops raise a flag and leave rd and enables clear
////////////////////////////////////////////////////////////
module mem_decode (
    input  logic              clk,
    input  logic              nrst,
    input  mem_pkg::mem_op_t  op,
    input  mem_pkg::word_t    base,
    input  mem_pkg::word_t    offset_i,    // I-type offset, loads
    input  mem_pkg::word_t    offset_s,    // S-type offset, stores
    input  mem_pkg::word_t    store_data,
    output mem_pkg::mem_req_t req,
    output logic              ld_misaligned,
    output logic              st_misaligned
);
    // stage 5
    mem_pkg::mem_op_t  op_5;
    mem_pkg::word_t    base_5;
    mem_pkg::word_t    offset_i_5;
    mem_pkg::word_t    offset_s_5;
    mem_pkg::word_t    store_data_5;
    mem_pkg::word_t    addr_5;
    mem_pkg::byte_en_t byte_en_5;
    logic              is_store_5;
    logic              misaligned_5;
    logic              rd_5;

    // stage 6
    mem_pkg::mem_op_t  op_6;
    mem_pkg::word_t    addr_6;
    mem_pkg::word_t    wdata_6;
    mem_pkg::byte_en_t byte_en_6;
    logic              rd_6;
    logic              active_6;
    logic              ld_mis_6;
    logic              st_mis_6;

    always_ff @(posedge clk, negedge nrst) begin
        if (!nrst) begin
            op_5 <= mem_pkg::NO_OP;
        end else begin
            op_5 <= op;
        end
    end

    always_ff @(posedge clk) begin
        base_5       <= base;
        offset_i_5   <= offset_i;
        offset_s_5   <= offset_s;
        store_data_5 <= store_data;
    end

    assign is_store_5 = op_5[3];
    assign addr_5     = base_5 + (is_store_5 ? offset_s_5 : offset_i_5);

    // half on odd address, word with either low bit set
    assign misaligned_5 = ((op_5[2:1] == 2'b01) & addr_5[0]) |
                          ((op_5[2:1] == 2'b11) & (|addr_5[1:0]));

    assign rd_5 = (op_5 != mem_pkg::NO_OP) & ~is_store_5 & ~misaligned_5;

    always_comb begin
        case (op_5)
            mem_pkg::SW: byte_en_5 = 4'b1111;
            mem_pkg::SH: byte_en_5 = addr_5[1] ? 4'b1100 : 4'b0011;
            mem_pkg::SB: byte_en_5 = mem_pkg::byte_en_t'(4'b0001 << addr_5[1:0]);
            default:     byte_en_5 = '0;    // loads, no-op
        endcase
        if (misaligned_5) begin
            byte_en_5 = '0;
        end
    end

    always_ff @(posedge clk, negedge nrst) begin
        if (!nrst) begin
            op_6      <= mem_pkg::NO_OP;
            byte_en_6 <= '0;
            rd_6      <= 1'b0;
            active_6  <= 1'b0;
            ld_mis_6  <= 1'b0;
            st_mis_6  <= 1'b0;
        end else begin
            op_6      <= op_5;
            byte_en_6 <= byte_en_5;
            rd_6      <= rd_5;
            active_6  <= (op_5 != mem_pkg::NO_OP);
            ld_mis_6  <= misaligned_5 & ~is_store_5;
            st_mis_6  <= misaligned_5 & is_store_5;
        end
    end

    always_ff @(posedge clk) begin
        addr_6  <= addr_5;
        wdata_6 <= store_data_5;
    end

    assign req = '{addr: addr_6, wdata: wdata_6, byte_en: byte_en_6,
                   rd: rd_6, op: op_6, active: active_6};

    assign ld_misaligned = ld_mis_6;
    assign st_misaligned = st_mis_6;

endmodule

// File: design/mem_pkg.sv
////////////////////////////////////////////////////////////
// shared types for the memory stage and its L1.5 port
// op encoding follows the decoder of the core
////////////////////////////////////////////////////////////
package mem_pkg;

    // bit 3 store, bits 2:1 width (11 word, 01 half, 10 byte),
    // bit 0 signed
    typedef enum logic [3:0] {
        NO_OP = 4'b0000,
        SW    = 4'b1111,
        SH    = 4'b1011,
        SB    = 4'b1101,
        LW    = 4'b0111,
        LH    = 4'b0011,
        LHU   = 4'b0010,
        LB    = 4'b0101,
        LBU   = 4'b0100
    } mem_op_t;

    typedef logic [31:0] word_t;     // data or address
    typedef logic [3:0]  byte_en_t;  // bit n enables byte n

    // stage-6 request from the decoder
    typedef struct packed {
        word_t    addr;
        word_t    wdata;
        byte_en_t byte_en;
        logic     rd;                // aligned load
        mem_op_t  op;
        logic     active;            // any nonzero op
    } mem_req_t;

    typedef struct packed {
        logic [3:0]  rqtype;
        logic [2:0]  size;
        word_t       address;
        logic [63:0] data;
        logic        val;
    } l15_req_t;

    typedef struct packed {
        logic [63:0] data_0;
        logic [63:0] data_1;
        logic [3:0]  returntype;
        logic        val;
        logic        header_ack;
    } l15_resp_t;

endpackage

// File: design/mem_params.svh
////////////////////////////////////////////////////////////
// L1.5 request, return and size codes as used by the memory
// stage. Only the subset needed for plain loads and stores
////////////////////////////////////////////////////////////
`ifndef MEM_PARAMS_SVH
`define MEM_PARAMS_SVH

// request types
`define LOAD_RQ      4'b0000
`define STORE_RQ     4'b0001

// return types seen on the response port
`define LOAD_RET     4'b0000
`define ST_ACK       4'b0100
`define INT_RET      4'b0111     // interrupt return, ignored here

// message data size, log2 of bytes plus one
`define MSG_SIZE_1B  3'b001
`define MSG_SIZE_2B  3'b010
`define MSG_SIZE_4B  3'b011

// the L1.5 line is two 64-bit halves, big-endian per word
// addr[3:2] picks data_0 upper, data_0 lower,
// data_1 upper, data_1 lower

`endif
